//--- cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Datapath width
`define XLEN 32

// Memory depths in words
`define IMEM_WORDS 256
`define DMEM_WORDS 256

// First fetch address
`define RESET_PC 32'h0000_0000

// ADDI x0, x0, 0
`define NOP_INSTR 32'h0000_0013

`endif

//--- cpu_pkg.sv
`default_nettype none
`include "cpu_defines.svh"

package cpu_pkg;

  typedef logic [`XLEN-1:0] word_t;
  typedef logic [4:0]       regIdx_t;

  typedef enum logic [3:0] {
    aluAdd, aluSub, aluAnd, aluOr, aluXor,
    aluSlt, aluSll, aluSrl, aluPassB
  } aluOp_t;

  typedef enum logic [1:0] {
    wbSrcAlu, wbSrcMem, wbSrcPcPlus4
  } wbSel_t;

  typedef enum logic [2:0] {
    immI, immS, immB, immU, immJ
  } immSel_t;

  // Operand source in execute
  typedef enum logic [1:0] {
    fwdReg, fwdFromMem, fwdFromWb
  } fwdSel_t;

  // Supported major opcodes
  typedef enum logic [6:0] {
    opLui    = 7'b0110111,
    opJal    = 7'b1101111,
    opBranch = 7'b1100011,
    opLoad   = 7'b0000011,
    opStore  = 7'b0100011,
    opImm    = 7'b0010011,
    opReg    = 7'b0110011
  } opcode_t;

endpackage

`default_nettype wire

//--- fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defines.svh"

module fetch_unit (
  input  wire                 clk,
  input  wire                 rst,
  input  wire                 stall,
  input  wire                 redirect,
  input  wire cpu_pkg::word_t redirectPc,
  output cpu_pkg::word_t      pc,
  output cpu_pkg::word_t      instr
);
  import cpu_pkg::*;

  localparam int IdxW = $clog2(`IMEM_WORDS);

  word_t rom [`IMEM_WORDS];

  initial begin
    $readmemh("program.hex", rom);
  end

  // Redirect wins over a stall
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RESET_PC;
    end else if (redirect) begin
      pc <= redirectPc;
    end else if (!stall) begin
      pc <= pc + 32'd4;
    end
  end

  // Word-addressed ROM read
  assign instr = rom[pc[IdxW+1:2]];

endmodule

`default_nettype wire

//--- decoder.sv
`timescale 1ns/10ps
`default_nettype none

module decoder (
  input  wire cpu_pkg::word_t instr,
  output cpu_pkg::regIdx_t    rs1,
  output cpu_pkg::regIdx_t    rs2,
  output cpu_pkg::regIdx_t    rd,
  output cpu_pkg::word_t      imm,
  output cpu_pkg::aluOp_t     aluOp,
  output logic                aluSrcImm,
  output logic                aluSrcPc,
  output logic                regWrite,
  output logic                memRead,
  output logic                memWrite,
  output cpu_pkg::wbSel_t     wbSel,
  output logic                isBranch,
  output logic                isJump,
  output logic [2:0]          branchFunct
);
  import cpu_pkg::*;

  opcode_t    opcode;
  immSel_t    immSel;
  logic [2:0] funct3;
  logic       useRs1;
  logic       useRs2;

  assign opcode = opcode_t'(instr[6:0]);
  assign funct3 = instr[14:12];

  // Unused source fields read as x0 so they never trigger a stall
  assign rs1 = useRs1 ? instr[19:15] : '0;
  assign rs2 = useRs2 ? instr[24:20] : '0;
  assign rd  = regWrite ? instr[11:7] : '0;
  assign branchFunct = funct3;

  ////////////////////////////////////////
  // Control fields
  ////////////////////////////////////////

  always_comb begin
    immSel    = immI;
    aluOp     = aluAdd;
    aluSrcImm = 1'b0;
    aluSrcPc  = 1'b0;
    regWrite  = 1'b0;
    memRead   = 1'b0;
    memWrite  = 1'b0;
    wbSel     = wbSrcAlu;
    isBranch  = 1'b0;
    isJump    = 1'b0;
    useRs1    = 1'b0;
    useRs2    = 1'b0;
    case (opcode)
      opLui: begin
        immSel    = immU;
        aluOp     = aluPassB;
        aluSrcImm = 1'b1;
        regWrite  = 1'b1;
      end
      opJal: begin
        // ALU forms the target, rd gets pc + 4
        immSel    = immJ;
        aluSrcPc  = 1'b1;
        aluSrcImm = 1'b1;
        regWrite  = 1'b1;
        wbSel     = wbSrcPcPlus4;
        isJump    = 1'b1;
      end
      opBranch: begin
        immSel   = immB;
        isBranch = 1'b1;
        useRs1   = 1'b1;
        useRs2   = 1'b1;
      end
      opLoad: begin
        aluSrcImm = 1'b1;
        regWrite  = 1'b1;
        memRead   = 1'b1;
        wbSel     = wbSrcMem;
        useRs1    = 1'b1;
      end
      opStore: begin
        immSel    = immS;
        aluSrcImm = 1'b1;
        memWrite  = 1'b1;
        useRs1    = 1'b1;
        useRs2    = 1'b1;
      end
      opImm, opReg: begin
        aluSrcImm = (opcode == opImm);
        regWrite  = 1'b1;
        useRs1    = 1'b1;
        useRs2    = (opcode == opReg);
        case (funct3)
          3'b000:  aluOp = (opcode == opReg && instr[30]) ? aluSub : aluAdd;
          3'b001:  aluOp = aluSll;
          3'b010:  aluOp = aluSlt;
          3'b100:  aluOp = aluXor;
          3'b101:  aluOp = aluSrl;
          3'b110:  aluOp = aluOr;
          3'b111:  aluOp = aluAnd;
          default: aluOp = aluAdd;
        endcase
      end
      default: begin
        // Anything else falls through as a bubble
      end
    endcase
  end

  ////////////////////////////////////////
  // Immediate generation
  ////////////////////////////////////////

  always_comb begin
    case (immSel)
      immS:    imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      immB:    imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      immU:    imm = {instr[31:12], 12'b0};
      immJ:    imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      default: imm = {{20{instr[31]}}, instr[31:20]};
    endcase
  end

endmodule

`default_nettype wire

//--- reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   we,
  input  wire cpu_pkg::regIdx_t waddr,
  input  wire cpu_pkg::regIdx_t raddr1,
  input  wire cpu_pkg::regIdx_t raddr2,
  input  wire cpu_pkg::word_t   wdata,
  output cpu_pkg::word_t        rdata1,
  output cpu_pkg::word_t        rdata2
);
  import cpu_pkg::*;

  word_t regs [32];

  // Architectural state starts at zero
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // Bypass the WB write into the ID read
  assign rdata1 = (raddr1 == '0) ? '0 :
                  (we && waddr == raddr1) ? wdata : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 :
                  (we && waddr == raddr2) ? wdata : regs[raddr2];

  x0StaysZero: assert property (@(posedge clk) disable iff (rst)
    regs[0] == '0);

endmodule

`default_nettype wire

//--- hazard_unit.sv
`timescale 1ns/10ps
`default_nettype none

module hazard_unit (
  input  wire cpu_pkg::regIdx_t idRs1,
  input  wire cpu_pkg::regIdx_t idRs2,
  input  wire cpu_pkg::regIdx_t exRs1,
  input  wire cpu_pkg::regIdx_t exRs2,
  input  wire cpu_pkg::regIdx_t exRd,
  input  wire cpu_pkg::regIdx_t memRd,
  input  wire cpu_pkg::regIdx_t wbRd,
  input  wire                   exMemRead,
  input  wire                   memRegWrite,
  input  wire                   wbRegWrite,
  output logic                  stall,
  output cpu_pkg::fwdSel_t      fwdA,
  output cpu_pkg::fwdSel_t      fwdB
);
  import cpu_pkg::*;

  // Load in EX feeding the instruction in ID
  assign stall = exMemRead && (exRd != '0) &&
                 ((exRd == idRs1) || (exRd == idRs2));

  ////////////////////////////////////////
  // Forwarding, youngest result first
  ////////////////////////////////////////

  always_comb begin
    fwdA = fwdReg;
    if (memRegWrite && memRd != '0 && memRd == exRs1) begin
      fwdA = fwdFromMem;
    end else if (wbRegWrite && wbRd != '0 && wbRd == exRs1) begin
      fwdA = fwdFromWb;
    end
  end

  always_comb begin
    fwdB = fwdReg;
    if (memRegWrite && memRd != '0 && memRd == exRs2) begin
      fwdB = fwdFromMem;
    end else if (wbRegWrite && wbRd != '0 && wbRd == exRs2) begin
      fwdB = fwdFromWb;
    end
  end

endmodule

`default_nettype wire

//--- execute_unit.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defines.svh"

module execute_unit (
  input  wire cpu_pkg::word_t   pc,
  input  wire cpu_pkg::word_t   rdata1,
  input  wire cpu_pkg::word_t   rdata2,
  input  wire cpu_pkg::word_t   imm,
  input  wire cpu_pkg::word_t   memResult,
  input  wire cpu_pkg::word_t   wbResult,
  input  wire cpu_pkg::fwdSel_t fwdA,
  input  wire cpu_pkg::fwdSel_t fwdB,
  input  wire cpu_pkg::aluOp_t  aluOp,
  input  wire                   aluSrcImm,
  input  wire                   aluSrcPc,
  input  wire                   isBranch,
  input  wire                   isJump,
  input  wire [2:0]             branchFunct,
  output cpu_pkg::word_t        aluResult,
  output cpu_pkg::word_t        storeData,
  output cpu_pkg::word_t        redirectPc,
  output logic                  redirect
);
  import cpu_pkg::*;

  word_t opA;
  word_t opB;
  word_t aluA;
  word_t aluB;
  logic  isEq;
  logic  isLt;
  logic  taken;

  // Forwarded register operands
  always_comb begin
    case (fwdA)
      fwdFromMem: opA = memResult;
      fwdFromWb:  opA = wbResult;
      default:    opA = rdata1;
    endcase
    case (fwdB)
      fwdFromMem: opB = memResult;
      fwdFromWb:  opB = wbResult;
      default:    opB = rdata2;
    endcase
  end

  assign aluA = aluSrcPc ? pc : opA;
  assign aluB = aluSrcImm ? imm : opB;

  always_comb begin
    case (aluOp)
      aluAdd:   aluResult = aluA + aluB;
      aluSub:   aluResult = aluA - aluB;
      aluAnd:   aluResult = aluA & aluB;
      aluOr:    aluResult = aluA | aluB;
      aluXor:   aluResult = aluA ^ aluB;
      aluSlt:   aluResult = {{(`XLEN-1){1'b0}}, $signed(aluA) < $signed(aluB)};
      aluSll:   aluResult = aluA << aluB[4:0];
      aluSrl:   aluResult = aluA >> aluB[4:0];
      aluPassB: aluResult = aluB;
      default:  aluResult = '0;
    endcase
  end

  ////////////////////////////////////////
  // Branch decision
  ////////////////////////////////////////

  assign isEq = (opA == opB);
  assign isLt = ($signed(opA) < $signed(opB));

  always_comb begin
    case (branchFunct)
      3'b000:  taken = isEq;
      3'b001:  taken = !isEq;
      3'b100:  taken = isLt;
      3'b101:  taken = !isLt;
      default: taken = 1'b0;
    endcase
  end

  assign redirect   = isJump || (isBranch && taken);
  assign redirectPc = pc + imm;
  assign storeData  = opB;

endmodule

`default_nettype wire

//--- data_mem.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defines.svh"

module data_mem (
  input  wire                 clk,
  input  wire                 we,
  input  wire cpu_pkg::word_t addr,
  input  wire cpu_pkg::word_t wdata,
  output cpu_pkg::word_t      rdata
);
  import cpu_pkg::*;

  localparam int IdxW = $clog2(`DMEM_WORDS);

  word_t mem [`DMEM_WORDS];

  initial begin
    for (int i = 0; i < `DMEM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  always @(posedge clk) begin
    if (we) begin
      mem[addr[IdxW+1:2]] <= wdata;
    end
  end

  // Combinational word read
  assign rdata = mem[addr[IdxW+1:2]];

  alignedInRange: assert property (@(posedge clk)
    we |-> (addr[1:0] == 2'b00) && (addr < `DMEM_WORDS * 4));

endmodule

`default_nettype wire

//--- cpu_top.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defines.svh"

module cpu_top (
  input  wire              clk,
  input  wire              rst,
  output logic             wbValid,
  output cpu_pkg::regIdx_t wbRd,
  output cpu_pkg::word_t   wbData,
  output logic             memWrite,
  output cpu_pkg::word_t   memAddr,
  output cpu_pkg::word_t   memWdata
);
  import cpu_pkg::*;

  // Fetch and hazard control
  word_t   fetchPc;
  word_t   fetchInstr;
  logic    stall;
  logic    redirect;
  word_t   redirectPc;
  fwdSel_t fwdA;
  fwdSel_t fwdB;

  // ID stage
  word_t      idInstr;
  word_t      idPc;
  regIdx_t    idRs1;
  regIdx_t    idRs2;
  regIdx_t    idRd;
  word_t      idImm;
  word_t      idRdata1;
  word_t      idRdata2;
  aluOp_t     idAluOp;
  wbSel_t     idWbSel;
  logic       idAluSrcImm;
  logic       idAluSrcPc;
  logic       idRegWrite;
  logic       idMemRead;
  logic       idMemWrite;
  logic       idIsBranch;
  logic       idIsJump;
  logic [2:0] idBranchFunct;

  // EX stage
  word_t      exPc;
  word_t      exRdata1;
  word_t      exRdata2;
  word_t      exImm;
  regIdx_t    exRs1;
  regIdx_t    exRs2;
  regIdx_t    exRd;
  aluOp_t     exAluOp;
  wbSel_t     exWbSel;
  logic       exAluSrcImm;
  logic       exAluSrcPc;
  logic       exRegWrite;
  logic       exMemRead;
  logic       exMemWrite;
  logic       exIsBranch;
  logic       exIsJump;
  logic [2:0] exBranchFunct;
  word_t      exAluResult;
  word_t      exStoreData;

  // MEM stage
  logic    memRegWrite;
  regIdx_t memRd;
  wbSel_t  memWbSel;
  word_t   memAlu;
  word_t   memStoreData;
  word_t   memPcPlus4;
  word_t   memFwdData;
  word_t   memRdata;

  // WB stage
  logic   wbRegWrite;
  wbSel_t wbSel;
  word_t  wbAlu;
  word_t  wbMemData;
  word_t  wbPcPlus4;

  fetch_unit u_fetch_unit (
    .clk(clk), .rst(rst), .stall(stall), .redirect(redirect),
    .redirectPc(redirectPc), .pc(fetchPc), .instr(fetchInstr)
  );

  // IF/ID holds on stall, bubbles on redirect
  always_ff @(posedge clk) begin
    if (rst || redirect) begin
      idInstr <= `NOP_INSTR;
    end else if (!stall) begin
      idInstr <= fetchInstr;
    end
    if (!stall) begin
      idPc <= fetchPc;
    end
  end

  decoder u_decoder (
    .instr(idInstr), .rs1(idRs1), .rs2(idRs2), .rd(idRd), .imm(idImm),
    .aluOp(idAluOp), .aluSrcImm(idAluSrcImm), .aluSrcPc(idAluSrcPc),
    .regWrite(idRegWrite), .memRead(idMemRead), .memWrite(idMemWrite),
    .wbSel(idWbSel), .isBranch(idIsBranch), .isJump(idIsJump),
    .branchFunct(idBranchFunct)
  );

  reg_file u_reg_file (
    .clk(clk), .rst(rst), .we(wbRegWrite), .waddr(wbRd),
    .raddr1(idRs1), .raddr2(idRs2), .wdata(wbData),
    .rdata1(idRdata1), .rdata2(idRdata2)
  );

  hazard_unit u_hazard_unit (
    .idRs1(idRs1), .idRs2(idRs2), .exRs1(exRs1), .exRs2(exRs2),
    .exRd(exRd), .memRd(memRd), .wbRd(wbRd), .exMemRead(exMemRead),
    .memRegWrite(memRegWrite), .wbRegWrite(wbRegWrite),
    .stall(stall), .fwdA(fwdA), .fwdB(fwdB)
  );

  ////////////////////////////////////////
  // ID/EX register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst || redirect || stall) begin
      exRegWrite <= 1'b0;
      exMemRead  <= 1'b0;
      exMemWrite <= 1'b0;
      exIsBranch <= 1'b0;
      exIsJump   <= 1'b0;
      exRd       <= '0;
      exRs1      <= '0;
      exRs2      <= '0;
    end else begin
      exRegWrite <= idRegWrite;
      exMemRead  <= idMemRead;
      exMemWrite <= idMemWrite;
      exIsBranch <= idIsBranch;
      exIsJump   <= idIsJump;
      exRd       <= idRd;
      exRs1      <= idRs1;
      exRs2      <= idRs2;
    end
    exPc          <= idPc;
    exRdata1      <= idRdata1;
    exRdata2      <= idRdata2;
    exImm         <= idImm;
    exAluOp       <= idAluOp;
    exWbSel       <= idWbSel;
    exAluSrcImm   <= idAluSrcImm;
    exAluSrcPc    <= idAluSrcPc;
    exBranchFunct <= idBranchFunct;
  end

  execute_unit u_execute_unit (
    .pc(exPc), .rdata1(exRdata1), .rdata2(exRdata2), .imm(exImm),
    .memResult(memFwdData), .wbResult(wbData), .fwdA(fwdA), .fwdB(fwdB),
    .aluOp(exAluOp), .aluSrcImm(exAluSrcImm), .aluSrcPc(exAluSrcPc),
    .isBranch(exIsBranch), .isJump(exIsJump), .branchFunct(exBranchFunct),
    .aluResult(exAluResult), .storeData(exStoreData),
    .redirectPc(redirectPc), .redirect(redirect)
  );

  ////////////////////////////////////////
  // EX/MEM and MEM/WB registers
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      memRegWrite <= 1'b0;
      memWrite    <= 1'b0;
      memRd       <= '0;
    end else begin
      memRegWrite <= exRegWrite;
      memWrite    <= exMemWrite;
      memRd       <= exRd;
    end
    memWbSel     <= exWbSel;
    memAlu       <= exAluResult;
    memStoreData <= exStoreData;
    memPcPlus4   <= exPc + 32'd4;
  end

  // Loads never forward from MEM thanks to the stall
  assign memFwdData = (memWbSel == wbSrcPcPlus4) ? memPcPlus4 : memAlu;

  data_mem u_data_mem (
    .clk(clk), .we(memWrite), .addr(memAlu), .wdata(memStoreData),
    .rdata(memRdata)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      wbRegWrite <= 1'b0;
      wbRd       <= '0;
    end else begin
      wbRegWrite <= memRegWrite;
      wbRd       <= memRd;
    end
    wbSel     <= memWbSel;
    wbAlu     <= memAlu;
    wbMemData <= memRdata;
    wbPcPlus4 <= memPcPlus4;
  end

  always_comb begin
    case (wbSel)
      wbSrcMem:     wbData = wbMemData;
      wbSrcPcPlus4: wbData = wbPcPlus4;
      default:      wbData = wbAlu;
    endcase
  end

  // Observation ports
  assign wbValid  = wbRegWrite && (wbRd != '0);
  assign memAddr  = memAlu;
  assign memWdata = memStoreData;

  // A load in MEM only holds its address, so nothing may forward from it
  loadNotForwardedFromMem: assert property (@(posedge clk) disable iff (rst)
    (memRegWrite && memWbSel == wbSrcMem) |->
      (fwdA != fwdFromMem) && (fwdB != fwdFromMem));

endmodule

`default_nettype wire

//--- cpu_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defines.svh"

module cpu_tb;
  import cpu_pkg::*;

  localparam int StepLimit     = 4096;
  localparam int MaxEvents     = StepLimit;
  localparam int ResetCycles   = 16;
  localparam int CyclesPerWord = 40;
  localparam int ImemIdxW      = $clog2(`IMEM_WORDS);
  localparam int DmemIdxW      = $clog2(`DMEM_WORDS);

  logic    clk = 1'b0;
  logic    rst = 1'b1;
  logic    wbValid;
  regIdx_t wbRd;
  word_t   wbData;
  logic    memWrite;
  word_t   memAddr;
  word_t   memWdata;

  // Program image and architectural state of the model
  word_t prog [`IMEM_WORDS];
  word_t modelRegs [32];
  word_t modelMem [`DMEM_WORDS];

  // Expected events in program order
  regIdx_t expRd [MaxEvents];
  word_t   expWrData [MaxEvents];
  word_t   expStAddr [MaxEvents];
  word_t   expStData [MaxEvents];
  int      wrTotal = 0;
  int      stTotal = 0;
  word_t   finalPc = '0;
  logic    modelDone = 1'b0;
  int      progWords = 0;

  int wrIdx          = 0;
  int stIdx          = 0;
  int selfJumpHits   = 0;
  int watchdogCycles = 0;
  int writeErrors    = 0;
  int zeroErrors     = 0;
  int storeErrors    = 0;
  int endErrors      = 0;

  cpu_top u_cpu_top (
    .clk(clk), .rst(rst), .wbValid(wbValid), .wbRd(wbRd), .wbData(wbData),
    .memWrite(memWrite), .memAddr(memAddr), .memWdata(memWdata)
  );

  always #50 clk = ~clk;

  ////////////////////////////////////////
  // Instruction-set model
  ////////////////////////////////////////

  function automatic word_t computeAlu(input logic [2:0] f3, input logic alt,
                                       input word_t x, input word_t y);
    case (f3)
      3'd0:    return alt ? x - y : x + y;
      3'd1:    return x << y[4:0];
      3'd2:    return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
      3'd4:    return x ^ y;
      3'd5:    return x >> y[4:0];
      3'd6:    return x | y;
      3'd7:    return x & y;
      default: return '0;
    endcase
  endfunction

  function automatic logic branchTaken(input logic [2:0] f3, input word_t x, input word_t y);
    case (f3)
      3'd0:    return x == y;
      3'd1:    return x != y;
      3'd4:    return $signed(x) < $signed(y);
      3'd5:    return $signed(x) >= $signed(y);
      default: return 1'b0;
    endcase
  endfunction

  task automatic buildExpectedEvents();
    word_t      pc;
    word_t      nextPc;
    word_t      ins;
    word_t      a;
    word_t      b;
    word_t      addr;
    word_t      result;
    word_t      immI;
    word_t      immS;
    word_t      immB;
    word_t      immJ;
    logic [2:0] f3;
    logic       writes;
    logic       bad;
    int         steps;
    pc    = `RESET_PC;
    steps = 0;
    bad   = 1'b0;
    for (int r = 0; r < 32; r++) begin
      modelRegs[r] = '0;
    end
    for (int w = 0; w < `DMEM_WORDS; w++) begin
      modelMem[w] = '0;
    end
    while (!modelDone && !bad && steps < StepLimit) begin
      ins    = prog[pc[ImemIdxW+1:2]];
      f3     = ins[14:12];
      a      = modelRegs[ins[19:15]];
      b      = modelRegs[ins[24:20]];
      immI   = {{20{ins[31]}}, ins[31:20]};
      immS   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      immB   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
      immJ   = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      nextPc = pc + 32'd4;
      result = '0;
      writes = 1'b0;
      case (ins[6:0])
        7'b0110111: begin
          result = {ins[31:12], 12'h000};
          writes = 1'b1;
        end
        7'b1101111: begin
          result = pc + 32'd4;
          writes = 1'b1;
          nextPc = pc + immJ;
          if (nextPc == pc) begin
            modelDone = 1'b1;
            finalPc   = pc;
          end
        end
        7'b1100011: begin
          bad = f3[1];
          if (branchTaken(f3, a, b)) begin
            nextPc = pc + immB;
          end
        end
        7'b0000011: begin
          bad    = (f3 != 3'd2);
          addr   = a + immI;
          result = modelMem[addr[DmemIdxW+1:2]];
          writes = 1'b1;
        end
        7'b0100011: begin
          bad  = (f3 != 3'd2);
          addr = a + immS;
          modelMem[addr[DmemIdxW+1:2]] = b;
          expStAddr[stTotal] = addr;
          expStData[stTotal] = b;
          stTotal++;
        end
        7'b0010011: begin
          bad    = (f3 == 3'd3) || (f3 == 3'd5 && ins[30]);
          result = computeAlu(f3, 1'b0, a, immI);
          writes = 1'b1;
        end
        7'b0110011: begin
          bad    = (f3 == 3'd3) || (f3 == 3'd5 && ins[30]);
          result = computeAlu(f3, ins[30], a, b);
          writes = 1'b1;
        end
        default: begin
          bad = 1'b1;
        end
      endcase
      if (bad) begin
        $display("Model stopped at unsupported instruction %h at pc %h", ins, pc);
      end else if (writes && ins[11:7] != 5'd0) begin
        modelRegs[ins[11:7]] = result;
        expRd[wrTotal]       = ins[11:7];
        expWrData[wrTotal]   = result;
        wrTotal++;
      end
      pc = nextPc;
      steps++;
    end
    if (!modelDone && !bad) begin
      $display("Model ran %0d steps without reaching a self-jump", StepLimit);
    end
  endtask

  task automatic printErrorCounts();
    $display("Error counts: write %0d, x0 %0d, store %0d, other %0d",
             writeErrors, zeroErrors, storeErrors, endErrors);
  endtask

  ////////////////////////////////////////
  // Event tracking and checks
  ////////////////////////////////////////

  always @(posedge clk) begin
    if (!rst && wbValid) begin
      wrIdx <= wrIdx + 1;
    end
    if (!rst && memWrite) begin
      stIdx <= stIdx + 1;
    end
    // Self-jump seen in EX, by the model's address
    if (!rst && u_cpu_top.exIsJump && u_cpu_top.exPc == finalPc) begin
      selfJumpHits <= selfJumpHits + 1;
    end
  end

  writeMatchesModel: assert property (@(posedge clk) disable iff (rst)
    wbValid |-> (wrIdx < wrTotal) && (wbRd == expRd[wrIdx]) &&
                (wbData == expWrData[wrIdx]))
    else begin
      writeErrors++;
      $display("Mismatch at %0t: write %0d expected x%0d = %h, observed x%0d = %h",
               $time, wrIdx, expRd[wrIdx], expWrData[wrIdx], wbRd, wbData);
    end

  noWriteToZero: assert property (@(posedge clk) disable iff (rst)
    wbValid |-> (wbRd != 5'd0))
    else begin
      zeroErrors++;
      $display("Mismatch at %0t: write to x0 reported with data %h", $time, wbData);
    end

  storeMatchesModel: assert property (@(posedge clk) disable iff (rst)
    memWrite |-> (stIdx < stTotal) && (memAddr == expStAddr[stIdx]) &&
                 (memWdata == expStData[stIdx]))
    else begin
      storeErrors++;
      $display("Mismatch at %0t: store %0d expected [%h] = %h, observed [%h] = %h",
               $time, stIdx, expStAddr[stIdx], expStData[stIdx], memAddr, memWdata);
    end

  ////////////////////////////////////////
  // Run control
  ////////////////////////////////////////

  initial begin
    $readmemh("program.hex", prog);
    buildExpectedEvents();
    if (modelDone) begin
      progWords      = int'(finalPc >> 2) + 1;
      watchdogCycles = ResetCycles + CyclesPerWord * progWords;
      repeat (ResetCycles) @(posedge clk);
      rst <= 1'b0;
      // Second pass of the self-jump means all older work has retired
      while (selfJumpHits < 2) begin
        @(posedge clk);
      end
      writeCountMatches: assert (wrIdx == wrTotal) else begin
        endErrors++;
        $display("Mismatch at %0t: %0d register writes retired, model expects %0d",
                 $time, wrIdx, wrTotal);
      end
      storeCountMatches: assert (stIdx == stTotal) else begin
        endErrors++;
        $display("Mismatch at %0t: %0d stores seen, model expects %0d",
                 $time, stIdx, stTotal);
      end
    end else begin
      endErrors++;
    end
    printErrorCounts();
    if (writeErrors + zeroErrors + storeErrors + endErrors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Watchdog scaled by program length
  initial begin
    wait (watchdogCycles != 0);
    repeat (watchdogCycles) @(posedge clk);
    $display("Timeout after %0d cycles: the DUT never reached the final self-jump",
             watchdogCycles);
    $display("Seen %0d of %0d writes and %0d of %0d stores",
             wrIdx, wrTotal, stIdx, stTotal);
    endErrors++;
    printErrorCounts();
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+.
cpu_pkg.sv
fetch_unit.sv
decoder.sv
reg_file.sv
hazard_unit.sv
execute_unit.sv
data_mem.sv
cpu_top.sv
cpu_tb.sv

//--- Makefile
SRCS := $(wildcard *.sv *.svh) verilog.f

obj_dir/Vcpu_tb: $(SRCS)
	verilator --binary --assert --timing --timescale 1ns/10ps -j 0 \
	  --top-module cpu_tb -f verilog.f

run: obj_dir/Vcpu_tb
	@out="$$(./obj_dir/Vcpu_tb)"; echo "$$out"; \
	  echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir

.PHONY: run clean

//--- program.hex
// One RV32I instruction word per line, in hex, starting at address 0
// Each word is followed by its assembly form
123450B7  // lui  x1, 0x12345
06400113  // addi x2, x0, 100
FFD10193  // addi x3, x2, -3
00218233  // add  x4, x3, x2
401202B3  // sub  x5, x4, x1
0F024313  // xori x6, x4, 0x0f0
10036393  // ori  x7, x6, 0x100
0FF3F413  // andi x8, x7, 0x0ff
00441493  // slli x9, x8, 4
00C0D513  // srli x10, x1, 12
0002A593  // slti x11, x5, 0
00312633  // slt  x12, x2, x3
00B116B3  // sll  x13, x2, x11
0080D733  // srl  x14, x1, x8
0043F7B3  // and  x15, x7, x4
0097E833  // or   x16, x15, x9
002848B3  // xor  x17, x16, x2
05102023  // sw   x17, 0x40(x0)
04002903  // lw   x18, 0x40(x0)
00190993  // addi x19, x18, 1
05302223  // sw   x19, 0x44(x0)
00310463  // beq  x2, x3, +8
00311463  // bne  x2, x3, +8
00100A13  // addi x20, x0, 1
0022C463  // blt  x5, x2, +8
00200A13  // addi x20, x0, 2
0022D463  // bge  x5, x2, +8
00314463  // blt  x2, x3, +8
00315463  // bge  x2, x3, +8
00300A13  // addi x20, x0, 3
00060463  // beq  x12, x0, +8
00400A13  // addi x20, x0, 4
00061463  // bne  x12, x0, +8
00800AEF  // jal  x21, +8
00500A13  // addi x20, x0, 5
000A8B13  // addi x22, x21, 0
00710013  // addi x0, x2, 7
0000006F  // jal  x0, 0
